//--- include/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// register file and bus data width.
`define LSU_XLEN 32

// byte address on the memory bus.
`define LSU_ADDR_WIDTH 32

`endif

//--- hdl/lsu_pkg.sv
`include "lsu_params.svh"

package lsu_pkg;

  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  typedef enum logic [1:0] {OP_NONE, OP_LOAD, OP_STORE} mem_op_e;

  // encoding follows funct3[1:0].
  typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_view_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_view_t;

  // loads read the word as I-type, stores as S-type.
  typedef union packed {
    i_view_t i_view;
    s_view_t s_view;
  } instr_u;

  typedef struct packed {
    instr_u              instr;
    logic [`LSU_XLEN-1:0] rs1;
    logic [`LSU_XLEN-1:0] rs2;
  } issue_t;

  typedef struct packed {
    mem_op_e              op;
    mem_size_e            size;
    logic                 is_unsigned;
    logic [`LSU_XLEN-1:0] imm;     // already sign extended.
    logic [4:0]           rd;
    logic                 illegal;
  } lsu_op_t;

  typedef struct packed {
    logic [`LSU_ADDR_WIDTH-1:0] addr;  // word aligned.
    logic                       write;
    logic [`LSU_XLEN-1:0]       wdata;
    logic [3:0]                 strb;
  } mem_req_t;

  typedef struct packed {
    logic [4:0]           rd;
    logic [`LSU_XLEN-1:0] data;
    logic                 reg_we;
    logic                 fault;
  } wb_t;

endpackage

//--- hdl/lsu_decode.sv
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_decode (
  input  lsu_pkg::instr_u  instr_i,
  output lsu_pkg::lsu_op_t op_o
);

  logic [2:0] funct3;

  assign funct3 = instr_i.i_view.funct3;  // same bits in both views.

  always_comb begin
    op_o.op          = lsu_pkg::OP_NONE;
    op_o.size        = lsu_pkg::SIZE_WORD;
    op_o.is_unsigned = 1'b0;
    op_o.imm         = '0;
    op_o.rd          = '0;
    op_o.illegal     = 1'b1;
    case (instr_i.i_view.opcode)
      lsu_pkg::OPC_LOAD: begin
        op_o.op  = lsu_pkg::OP_LOAD;
        op_o.rd  = instr_i.i_view.rd;
        op_o.imm = {{(`LSU_XLEN-12){instr_i.i_view.imm[11]}}, instr_i.i_view.imm};
        case (funct3)
          3'b000, 3'b001, 3'b010: begin
            op_o.size    = lsu_pkg::mem_size_e'(funct3[1:0]);
            op_o.illegal = 1'b0;
          end
          3'b100, 3'b101: begin
            op_o.size        = lsu_pkg::mem_size_e'(funct3[1:0]);
            op_o.is_unsigned = 1'b1;
            op_o.illegal     = 1'b0;
          end
          default: op_o.illegal = 1'b1;  // no LWU or wider on rv32.
        endcase
      end
      lsu_pkg::OPC_STORE: begin
        // rd field holds imm_lo here, so rd stays zero.
        op_o.op  = lsu_pkg::OP_STORE;
        op_o.imm = {{(`LSU_XLEN-12){instr_i.s_view.imm_hi[6]}},
                    instr_i.s_view.imm_hi, instr_i.s_view.imm_lo};
        if (funct3 <= 3'b010) begin
          op_o.size    = lsu_pkg::mem_size_e'(funct3[1:0]);
          op_o.illegal = 1'b0;
        end
      end
      default: begin
        op_o.op      = lsu_pkg::OP_NONE;
        op_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

//--- hdl/lsu_execute.sv
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_execute (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 issue_valid_i,
  input  lsu_pkg::lsu_op_t     op_i,
  input  logic [`LSU_XLEN-1:0] rs1_i,
  input  logic [`LSU_XLEN-1:0] rs2_i,
  output logic                 issue_ready_o,
  output logic                 mem_req_valid_o,
  output lsu_pkg::mem_req_t    mem_req_o,
  input  logic                 mem_req_ready_i,
  input  logic                 mem_rsp_valid_i,
  output logic                 done_o,
  output lsu_pkg::lsu_op_t     done_op_o,
  output logic [1:0]           offset_o,
  output logic                 fault_o
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT} state_e;

  state_e               state;
  logic                 fault_q;  // fault strobe pending.
  logic                 drain_q;  // write-back cycle, still busy.
  logic                 accept;
  logic                 misaligned;
  logic                 fault_d;
  logic [`LSU_XLEN-1:0] eff_addr;
  logic [3:0]           strb_base;
  lsu_pkg::mem_req_t    req_d;
  lsu_pkg::mem_req_t    req_q;
  lsu_pkg::lsu_op_t     op_q;
  logic [1:0]           offset_q;

  assign issue_ready_o = (state == S_IDLE) && !fault_q && !drain_q;
  assign accept        = issue_valid_i && issue_ready_o;

  always_comb begin
    eff_addr = rs1_i + op_i.imm;
    case (op_i.size)
      lsu_pkg::SIZE_BYTE: begin
        strb_base  = 4'b0001;
        misaligned = 1'b0;
      end
      lsu_pkg::SIZE_HALF: begin
        strb_base  = 4'b0011;
        misaligned = eff_addr[0];
      end
      default: begin
        strb_base  = 4'b1111;
        misaligned = |eff_addr[1:0];
      end
    endcase
    fault_d = op_i.illegal || misaligned;

    req_d.addr  = {eff_addr[`LSU_ADDR_WIDTH-1:2], 2'b00};
    req_d.write = (op_i.op == lsu_pkg::OP_STORE);
    req_d.wdata = rs2_i << {eff_addr[1:0], 3'b000};  // move data into its lane.
    req_d.strb  = strb_base << eff_addr[1:0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= S_IDLE;
      fault_q <= 1'b0;
      drain_q <= 1'b0;
    end else begin
      drain_q <= done_o;
      fault_q <= 1'b0;
      case (state)
        S_IDLE: begin
          if (accept) begin
            if (fault_d) fault_q <= 1'b1;  // no bus access.
            else state <= S_REQ;
          end
        end
        S_REQ: begin
          if (mem_req_ready_i) state <= mem_rsp_valid_i ? S_IDLE : S_WAIT;
        end
        S_WAIT: begin
          if (mem_rsp_valid_i) state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q     <= op_i;
      offset_q <= eff_addr[1:0];
      req_q    <= req_d;
    end
  end

  assign mem_req_valid_o = (state == S_REQ);
  assign mem_req_o       = req_q;

  // a response may come back in the same cycle the request is taken.
  assign done_o    = fault_q || (mem_rsp_valid_i &&
                     (state == S_WAIT || (state == S_REQ && mem_req_ready_i)));
  assign done_op_o = op_q;
  assign offset_o  = offset_q;
  assign fault_o   = fault_q;

endmodule

//--- hdl/lsu_result.sv
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_result (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 done_i,
  input  lsu_pkg::lsu_op_t     op_i,
  input  logic [1:0]           offset_i,
  input  logic                 fault_i,
  input  logic [`LSU_XLEN-1:0] rdata_i,
  output logic                 wb_valid_o,
  output lsu_pkg::wb_t         wb_o
);

  logic [`LSU_XLEN-1:0] shifted;
  logic [`LSU_XLEN-1:0] load_val;
  logic                 is_load;
  lsu_pkg::wb_t         wb_d;

  assign shifted = rdata_i >> {offset_i, 3'b000};  // addressed byte to bit 0.
  assign is_load = (op_i.op == lsu_pkg::OP_LOAD) && !fault_i;

  always_comb begin
    case (op_i.size)
      lsu_pkg::SIZE_BYTE: begin
        if (op_i.is_unsigned) load_val = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
        else load_val = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
      end
      lsu_pkg::SIZE_HALF: begin
        if (op_i.is_unsigned) load_val = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
        else load_val = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
      end
      default: load_val = shifted;
    endcase
  end

  always_comb begin
    wb_d.rd     = op_i.rd;
    wb_d.data   = is_load ? load_val : '0;
    wb_d.reg_we = is_load && (op_i.rd != 5'd0);  // x0 is never written.
    wb_d.fault  = fault_i;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= done_i;
    end
  end

  always_ff @(posedge clk) begin
    if (done_i) wb_o <= wb_d;
  end

endmodule

//--- hdl/lsu_top.sv
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 issue_valid_i,
  input  lsu_pkg::issue_t      issue_i,
  output logic                 issue_ready_o,
  output logic                 mem_req_valid_o,
  output lsu_pkg::mem_req_t    mem_req_o,
  input  logic                 mem_req_ready_i,
  input  logic                 mem_rsp_valid_i,
  input  logic [`LSU_XLEN-1:0] mem_rsp_rdata_i,
  output logic                 wb_valid_o,
  output lsu_pkg::wb_t         wb_o
);

  lsu_pkg::lsu_op_t dec_op;
  lsu_pkg::lsu_op_t done_op;
  logic             done;
  logic [1:0]       offset;
  logic             fault;

  lsu_decode lsu_decode_i (
    .instr_i (issue_i.instr),
    .op_o    (dec_op)
  );

  lsu_execute lsu_execute_i (
    .clk             (clk),
    .reset           (reset),
    .issue_valid_i   (issue_valid_i),
    .op_i            (dec_op),
    .rs1_i           (issue_i.rs1),
    .rs2_i           (issue_i.rs2),
    .issue_ready_o   (issue_ready_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .done_o          (done),
    .done_op_o       (done_op),
    .offset_o        (offset),
    .fault_o         (fault)
  );

  // read data is taken straight from the bus in the done cycle.
  lsu_result lsu_result_i (
    .clk        (clk),
    .reset      (reset),
    .done_i     (done),
    .op_i       (done_op),
    .offset_i   (offset),
    .fault_i    (fault),
    .rdata_i    (mem_rsp_rdata_i),
    .wb_valid_o (wb_valid_o),
    .wb_o       (wb_o)
  );

endmodule

//--- tb/lsu_top_properties.sv
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_top_properties (
  input logic              clk,
  input logic              reset,
  input logic              issue_ready_i,
  input logic              mem_req_valid_i,
  input lsu_pkg::mem_req_t mem_req_i,
  input logic              mem_req_ready_i,
  input logic              wb_valid_i,
  input lsu_pkg::wb_t      wb_i
);

  // a faulting access never touches the bus.
  fault_no_bus: assert property (@(posedge clk) disable iff (reset)
    wb_valid_i && wb_i.fault |-> !mem_req_valid_i && $past(!mem_req_valid_i))
    else $error("bus request seen around a faulting write-back");

  req_held: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
    else $error("bus request changed while stalled");

  // first cycle out of reset.
  reset_state: assert property (@(posedge clk)
    $fell(reset) |-> issue_ready_i && !mem_req_valid_i && !wb_valid_i)
    else $error("outputs not idle after reset");

endmodule

bind lsu_top lsu_top_properties lsu_top_properties_i (
  .clk             (clk),
  .reset           (reset),
  .issue_ready_i   (issue_ready_o),
  .mem_req_valid_i (mem_req_valid_o),
  .mem_req_i       (mem_req_o),
  .mem_req_ready_i (mem_req_ready_i),
  .wb_valid_i      (wb_valid_o),
  .wb_i            (wb_o)
);

//--- tb/lsu_top_tb.sv
`timescale 1ns/1ns
`include "lsu_params.svh"

module lsu_top_tb;

  localparam int NUM_INSTR = 54;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic issue_valid_i = 1'b0;
  lsu_pkg::issue_t issue_i = '0;
  logic issue_ready_o;
  logic mem_req_valid_o;
  logic wb_valid_o;
  lsu_pkg::mem_req_t mem_req_o;
  lsu_pkg::wb_t wb_o;
  logic mem_req_ready_i = 1'b0;
  logic mem_rsp_valid_i = 1'b0;
  logic [`LSU_XLEN-1:0] mem_rsp_rdata_i = '0;

  integer seed = 32'h636b_2e0f;
  int errors = 0;
  int accepted = 0;
  int wb_count = 0;
  logic [31:0] mem [256];
  logic [31:0] shadow [256];  // expected memory contents.
  lsu_pkg::mem_req_t last_req;
  logic req_seen;
  lsu_pkg::wb_t wb_got;

  lsu_top lsu_top_i (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    #1;
    if (!reset && wb_valid_o) wb_count++;
  end

  // memory with random stall and response delay.
  always begin : memory_model
    int d;
    int r;
    @(posedge clk);
    #1;
    if (!reset && mem_req_valid_o) begin
      req_seen = 1'b1;
      d = $random(seed) & 3;
      repeat (d) begin
        @(posedge clk);
        #1;
      end
      last_req = mem_req_o;
      mem_req_ready_i = 1'b1;
      r = $random(seed) & 3;
      mem_rsp_rdata_i = mem[last_req.addr[9:2]];
      mem_rsp_valid_i = (r == 0);
      @(posedge clk);
      #1;
      mem_req_ready_i = 1'b0;
      mem_rsp_valid_i = 1'b0;
      if (r != 0) begin
        repeat (r - 1) begin
          @(posedge clk);
          #1;
        end
        mem_rsp_valid_i = 1'b1;
        @(posedge clk);
        #1;
        mem_rsp_valid_i = 1'b0;
      end
      for (int i = 0; i < 4; i++)
        if (last_req.write && last_req.strb[i])
          mem[last_req.addr[9:2]][8*i +: 8] = last_req.wdata[8*i +: 8];
    end
  end

  task automatic check(input bit ok, input string msg);
    assert (ok) else begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
    end
  endtask

  // one instruction from issue to write-back.
  task automatic issue(input logic [31:0] word, input logic [31:0] rs1, input logic [31:0] rs2);
    @(posedge clk);
    #1;
    while (!issue_ready_o) begin
      @(posedge clk);
      #1;
    end
    req_seen = 1'b0;
    issue_valid_i = 1'b1;
    issue_i = {word, rs1, rs2};
    @(posedge clk);
    #1;
    issue_valid_i = 1'b0;
    accepted++;
    while (!wb_valid_o) begin
      check(!issue_ready_o, "issue_ready_o high before write-back");
      @(posedge clk);
      #1;
    end
    wb_got = wb_o;
  endtask

  task automatic run_load(input logic [2:0] f3, input int off, input int widx);
    logic [4:0] rd;
    logic [11:0] imm;
    logic [31:0] sh;
    logic [31:0] data;
    logic bad;
    lsu_pkg::wb_t exp;
    rd = (off == 3) ? 5'd0 : 5'($random(seed));  // x0 target at offset 3.
    imm = 12'(off - 8);  // negative offset from the base register.
    sh = shadow[widx] >> (8 * off);
    issue({imm, 5'd1, f3, rd, 7'b0000011}, widx * 4 + 8, 32'd0);
    bad = (f3 == 3'd3) || (f3 > 3'd5) || (f3[1:0] == 2'd1 && off[0]) ||
          (f3[1:0] == 2'd2 && off != 0);
    case (f3[1:0])
      2'd0: data = f3[2] ? {24'b0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
      2'd1: data = f3[2] ? {16'b0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
      default: data = sh;
    endcase
    exp.rd = rd;
    exp.data = bad ? 32'd0 : data;
    exp.reg_we = !bad && rd != 5'd0;
    exp.fault = bad;
    check(wb_got == exp, $sformatf("load f3=%0d off=%0d got %h", f3, off, wb_got));
    check(req_seen == !bad, "bus activity does not match fault");
    if (!bad)
      check(!last_req.write && last_req.addr == widx * 4,
            $sformatf("load request %h", last_req));
  endtask

  task automatic run_store(input logic [2:0] f3, input int off, input int widx);
    logic [11:0] imm;
    logic [31:0] rs2;
    logic [3:0] strb;
    logic bad;
    rs2 = $random(seed);
    imm = 12'(off - 8);
    strb = (f3 == 0 ? 4'b0001 : f3 == 1 ? 4'b0011 : 4'b1111) << off;
    bad = (f3 > 3'd2) || (f3 == 3'd1 && off[0]) || (f3 == 3'd2 && off != 0);
    issue({imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011}, widx * 4 + 8, rs2);
    check(wb_got.fault == bad && !wb_got.reg_we && wb_got.data == 0, "store write-back");
    check(req_seen == !bad, "bus activity does not match fault");
    if (!bad) begin
      check(last_req.write && last_req.strb == strb && last_req.addr == widx * 4,
            $sformatf("store request %h", last_req));
      for (int i = 0; i < 4; i++)
        if (strb[i]) begin
          check(last_req.wdata[8*i +: 8] == rs2[8*(i-off) +: 8], "store lane data");
          shadow[widx][8*i +: 8] = rs2[8*(i-off) +: 8];
        end
    end
  endtask

  initial begin : watchdog
    #((NUM_INSTR * 12 + 16) * 100);
    $display("timeout: the tests did not finish in the expected time");
    $display("Errors found");
    $finish;
  end

  initial begin
    int idx;
    for (int i = 0; i < 256; i++) begin
      mem[i] = $random(seed);
      shadow[i] = mem[i];
    end
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;
    for (int f = 0; f < 6; f++)
      if (f != 3)
        for (int off = 0; off < 4; off++) run_load(3'(f), off, $random(seed) & 255);
    for (int f = 0; f < 3; f++)
      for (int off = 0; off < 4; off++) begin
        idx = $random(seed) & 255;
        run_store(3'(f), off, idx);
        run_load((f == 2) ? 3'd2 : 3'(f + 4), off, idx);  // same word, zero-extended.
      end
    run_load(3'd3, 0, $random(seed) & 255);
    run_load(3'd6, 0, $random(seed) & 255);
    run_load(3'd7, 0, $random(seed) & 255);
    for (int f = 3; f < 8; f++) run_store(3'(f), 0, $random(seed) & 255);
    issue(32'h0000_0013, 32'd0, 32'd0);
    check(wb_got.fault && !req_seen, "addi not faulted");
    issue(32'h0000_006f, 32'd0, 32'd0);
    check(wb_got.fault && !req_seen, "jal not faulted");
    repeat (2) @(posedge clk);
    #1;
    check(wb_count == accepted, "write-back pulse count differs from accepted count");
    $display("summary: %0d failed checks, %0d accepted, %0d write-backs",
             errors, accepted, wb_count);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- lsu_top.f
+incdir+include
hdl/lsu_pkg.sv
hdl/lsu_decode.sv
hdl/lsu_execute.sv
hdl/lsu_result.sv
hdl/lsu_top.sv
tb/lsu_top_properties.sv
tb/lsu_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lsu_top_tb
FILELIST  ?= lsu_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
